/* vlog.f */
+incdir+source
source/bus_cmd_pkg.sv
source/serial_bus_pkg.sv
source/cmd_capture.sv
source/cmd_fifo.sv
source/bus_sequencer.sv
source/serial_master_top.sv
bench/slave_model.sv
bench/tb_serial_master.sv

/* bench/tb_serial_master.sv */
`timescale 1ns/100ps
`default_nettype none

`include "bus_defs.svh"

module tb_serial_master;

	import bus_cmd_pkg::*;
	import serial_bus_pkg::*;

	localparam int clock_period = 40;
	localparam int reset_cycles = 16;
	localparam logic [31:0] seed_value = 32'h8954_aed7;
	localparam int n_random = 32;
	// random phase plus the held-bus phase
	localparam int n_cmds = n_random + `CMD_DEPTH + 1;
	localparam int limit_cycles = n_cmds * 60 + reset_cycles;

	logic clock;
	logic reset;
	logic enable;
	logic read_en;
	logic [`ADDR_W-1:0] addr_in;
	logic [`DATA_W-1:0] data_in;
	logic bus_ready;
	logic slave_valid;
	logic data_rx;
	logic master_busy;
	bus_tx_t tx;
	logic [`DATA_W-1:0] data_read;
	logic read_done;

	// slave side view of each transfer
	logic xfer_done;
	logic xfer_read;
	logic [`ADDR_W-1:0] xfer_addr;
	logic [`DATA_W-1:0] xfer_data;

	// posted commands, reads carry the word they must return
	bus_cmd_t posted_cmds [$];
	bus_cmd_t head_cmd = '0;
	logic head_valid = 1'b0;
	logic [`DATA_W-1:0] ref_mem [logic [`ADDR_W-1:0]];

	integer seed;
	integer ready_seed;
	logic [31:0] r;
	logic [`ADDR_W-1:0] base;
	int i;
	int gap_left = 0;
	logic hold_bus = 1'b0;
	logic granted = 1'b0;
	logic busy_seen = 1'b0;
	int valid_len = 0;
	int error_count = 0;
	int posted = 0;
	int writes_done = 0;
	int reads_done = 0;

	serial_master_top u_serial_master_top
	(
		.clock(clock),
		.reset(reset),
		.enable(enable),
		.read_en(read_en),
		.addr_in(addr_in),
		.data_in(data_in),
		.bus_ready(bus_ready),
		.slave_valid(slave_valid),
		.data_rx(data_rx),
		.master_busy(master_busy),
		.tx(tx),
		.data_read(data_read),
		.read_done(read_done)
	);

	slave_model #(.seed_init(seed_value)) u_slave_model
	(
		.clock(clock),
		.reset(reset),
		.tx(tx),
		.slave_valid(slave_valid),
		.data_rx(data_rx),
		.xfer_done(xfer_done),
		.xfer_read(xfer_read),
		.xfer_addr(xfer_addr),
		.xfer_data(xfer_data)
	);

	//////////////////////////////
	// error reporting
	//////////////////////////////

	task automatic report_value(input string name, input logic [31:0] exp, input logic [31:0] got);
		error_count++;
		$display("error: %s expected %0h got %0h", name, exp, got);
	endtask

	task automatic report_text(input string msg);
		error_count++;
		$display("%s", msg);
	endtask

	//////////////////////////////
	// clock and bus grant
	//////////////////////////////

	initial
	begin
		clock = 1'b0;
		forever
		begin
			#(clock_period / 2) clock = ~clock;
		end
	end

	// grant mostly given, dropped for random stretches
	initial
	begin
		ready_seed = seed_value;
		bus_ready = 1'b0;
		forever
		begin
			@(posedge clock);
			if (hold_bus || reset)
			begin
				bus_ready <= 1'b0;
			end
			else if (gap_left > 0)
			begin
				gap_left--;
				bus_ready <= 1'b0;
			end
			else
			begin
				bus_ready <= 1'b1;
				if (($random(ready_seed) & 3) == 0)
				begin
					gap_left = 1 + ($unsigned($random(ready_seed)) % 12);
				end
			end
		end
	end

	//////////////////////////////
	// scoreboard and trackers
	//////////////////////////////

	always @(posedge clock)
	begin
		if (!reset && head_valid && ((xfer_done && !xfer_read) || read_done))
		begin
			if (read_done)
			begin
				reads_done++;
			end
			else
			begin
				writes_done++;
			end
			void'(posted_cmds.pop_front());
		end
		head_valid <= (posted_cmds.size() > 0);
		head_cmd <= (posted_cmds.size() > 0) ? posted_cmds[0] : '0;
	end

	// grant seen since bus_req rose
	always @(posedge clock)
	begin
		if (reset || !tx.bus_req)
		begin
			granted <= 1'b0;
		end
		else if (bus_ready)
		begin
			granted <= 1'b1;
		end
		valid_len <= tx.valid_s ? valid_len + 1 : 0;
		if (master_busy)
		begin
			busy_seen <= 1'b1;
		end
	end

	//////////////////////////////
	// checks
	//////////////////////////////

	a_reset_tx : assert property (@(posedge clock) $fell(reset) |-> tx == '0)
		else report_value("tx", 0, $sampled(tx));
	a_reset_data : assert property (@(posedge clock) $fell(reset) |-> data_read == '0)
		else report_value("data_read", 0, $sampled(data_read));
	a_reset_flags : assert property (@(posedge clock) $fell(reset)
		|-> !read_done && !master_busy && u_serial_master_top.u_cmd_fifo.empty)
		else report_text("read_done, master_busy or queue state wrong after reset");

	a_head_valid : assert property (@(posedge clock) disable iff (reset)
		(xfer_done || read_done) |-> head_valid)
		else report_text("transfer seen with no command outstanding");
	a_xfer_dir : assert property (@(posedge clock) disable iff (reset)
		xfer_done |-> xfer_read == head_cmd.read)
		else report_value("write_en_slave", !$sampled(head_cmd.read), !$sampled(xfer_read));
	a_xfer_addr : assert property (@(posedge clock) disable iff (reset)
		xfer_done |-> xfer_addr == head_cmd.addr)
		else report_value("addr_tx", $sampled(head_cmd.addr), $sampled(xfer_addr));
	a_xfer_data : assert property (@(posedge clock) disable iff (reset)
		xfer_done && !xfer_read |-> xfer_data == head_cmd.data)
		else report_value("data_tx", $sampled(head_cmd.data), $sampled(xfer_data));
	a_read_cmd : assert property (@(posedge clock) disable iff (reset)
		read_done |-> head_cmd.read)
		else report_text("read_done pulsed for a write command");
	a_read_data : assert property (@(posedge clock) disable iff (reset)
		read_done |-> data_read == head_cmd.data)
		else report_value("data_read", $sampled(head_cmd.data), $sampled(data_read));

	a_grant_first : assert property (@(posedge clock) disable iff (reset)
		$rose(tx.valid_s) |-> granted)
		else report_text("valid_s rose before bus_ready was seen");
	a_valid_req : assert property (@(posedge clock) disable iff (reset)
		tx.valid_s |-> tx.bus_req)
		else report_text("valid_s high without bus_req");
	a_valid_long : assert property (@(posedge clock) disable iff (reset)
		tx.valid_s |-> valid_len < `ADDR_W)
		else report_text("valid_s held past the address phase");
	a_valid_len : assert property (@(posedge clock) disable iff (reset)
		$fell(tx.valid_s) |-> valid_len == `ADDR_W)
		else report_value("valid_s length", `ADDR_W, $sampled(valid_len));
	a_valid_state : assert property (@(posedge clock) disable iff (reset)
		tx.valid_s |-> u_serial_master_top.u_bus_sequencer.state == st_address)
		else report_value("state", st_address, $sampled(u_serial_master_top.u_bus_sequencer.state));

	//////////////////////////////
	// stimulus
	//////////////////////////////

	// enable held two edges so the push cycle sees stable inputs
	task automatic post_command(input logic rd, input logic [`ADDR_W-1:0] a,
		input logic [`DATA_W-1:0] d);
		bus_cmd_t cmd;
		cmd.read = rd;
		cmd.addr = a;
		cmd.data = d;
		// commands complete in order, so the read result is known now
		if (rd)
		begin
			cmd.data = ref_mem.exists(a) ? ref_mem[a] : a[`DATA_W-1:0];
		end
		else
		begin
			ref_mem[a] = d;
		end
		@(posedge clock);
		while (master_busy)
		begin
			@(posedge clock);
		end
		enable <= 1'b1;
		read_en <= rd;
		addr_in <= a;
		data_in <= d;
		@(posedge clock);
		@(posedge clock);
		posted_cmds.push_back(cmd);
		posted++;
		enable <= 1'b0;
		@(posedge clock);
	endtask

	task automatic wait_drained();
		while (posted_cmds.size() != 0)
		begin
			@(posedge clock);
		end
		repeat (2) @(posedge clock);
	endtask

	initial
	begin
		seed = seed_value;
		reset = 1'b1;
		enable = 1'b0;
		read_en = 1'b0;
		addr_in = '0;
		data_in = '0;
		repeat (reset_cycles) @(posedge clock);
		reset <= 1'b0;

		// mixed traffic, a few hot addresses so reads hit writes
		for (i = 0; i < n_random; i++)
		begin
			r = $random(seed);
			post_command(r[2:0] < 3'd3, r[31] ? {r[30:28], 11'h2d6} : r[29:16], r[15:8]);
			repeat (r[5:4]) @(posedge clock);
		end
		wait_drained();

		// bus withheld, queue fills behind the first command
		hold_bus <= 1'b1;
		repeat (2) @(posedge clock);
		r = $random(seed);
		base = {r[13:3], 3'b000};
		for (i = 0; i < `CMD_DEPTH; i++)
		begin
			post_command(1'b0, base + `ADDR_W'(i), r[23:16] ^ `DATA_W'(i));
		end
		post_command(1'b1, base, 8'h00);
		repeat (8) @(posedge clock);
		hold_bus <= 1'b0;
		wait_drained();

		assert (busy_seen)
			else report_text("master_busy never rose while the bus was held");
		$display("summary: %0d commands posted, %0d writes and %0d reads completed, %0d errors",
			posted, writes_done, reads_done, error_count);
		if (error_count == 0)
		begin
			$display("Regression passed");
		end
		else
		begin
			$display("Regression failed");
		end
		$finish;
	end

	// watchdog
	initial
	begin
		repeat (limit_cycles) @(posedge clock);
		$display("timeout: commands still outstanding after %0d cycles", limit_cycles);
		$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

/* bench/slave_model.sv */
`timescale 1ns/100ps
`default_nettype none

`include "bus_defs.svh"

module slave_model
#(
	parameter int seed_init = 1
)
(
	input wire logic clock,
	input wire logic reset,
	// lines from the master
	input wire serial_bus_pkg::bus_tx_t tx,
	output logic slave_valid,
	output logic data_rx,
	// one pulse per address phase, fields hold what was seen
	output logic xfer_done,
	output logic xfer_read,
	output logic [`ADDR_W-1:0] xfer_addr,
	output logic [`DATA_W-1:0] xfer_data
);

	import serial_bus_pkg::*;

	// written words, sparse
	logic [`DATA_W-1:0] mem [logic [`ADDR_W-1:0]];
	integer seed;
	logic [`ADDR_W-1:0] addr_sr;
	logic [`DATA_W-1:0] data_sr;
	logic is_read;
	int delay;

	// unwritten locations answer with their own low address bits
	function automatic logic [`DATA_W-1:0] read_word(input logic [`ADDR_W-1:0] a);
		if (mem.exists(a))
		begin
			return mem[a];
		end
		else
		begin
			return a[`DATA_W-1:0];
		end
	endfunction

	//////////////////////////////
	// deserialize one phase
	//////////////////////////////

	// entered on the first cycle with valid_s high
	task automatic take_phase();
		int k;
		is_read = ~tx.write_en_slave;
		addr_sr = '0;
		data_sr = '0;
		for (k = 0; k < `ADDR_W; k++)
		begin
			if (k > 0)
			begin
				@(posedge clock);
			end
			addr_sr = {addr_sr[`ADDR_W-2:0], tx.addr_tx};
			// write data only on the last DATA_W address cycles
			if (k >= `ADDR_W - `DATA_W)
			begin
				data_sr = {data_sr[`DATA_W-2:0], tx.data_tx};
			end
		end
	endtask

	// strobe, then the word msb first
	task automatic answer_read(input logic [`DATA_W-1:0] word);
		int i;
		delay = 1 + ($unsigned($random(seed)) % 5);
		repeat (delay) @(posedge clock);
		slave_valid <= 1'b1;
		@(posedge clock);
		slave_valid <= 1'b0;
		for (i = `DATA_W - 1; i >= 0; i--)
		begin
			data_rx <= word[i];
			@(posedge clock);
		end
		data_rx <= 1'b0;
	endtask

	//////////////////////////////
	// slave main loop
	//////////////////////////////

	initial
	begin
		seed = seed_init;
		slave_valid = 1'b0;
		data_rx = 1'b0;
		xfer_done = 1'b0;
		xfer_read = 1'b0;
		xfer_addr = '0;
		xfer_data = '0;
		forever
		begin
			@(posedge clock);
			if (!reset && tx.valid_s)
			begin
				take_phase();
				xfer_read <= is_read;
				xfer_addr <= addr_sr;
				xfer_data <= data_sr;
				xfer_done <= 1'b1;
				// valid_s seen low here
				@(posedge clock);
				xfer_done <= 1'b0;
				if (is_read)
				begin
					answer_read(read_word(addr_sr));
				end
				else
				begin
					mem[addr_sr] = data_sr;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* source/serial_master_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "bus_defs.svh"

module serial_master_top
(
	input wire logic clock,
	input wire logic reset,
	// user command inputs
	input wire logic enable,
	input wire logic read_en,
	input wire logic [`ADDR_W-1:0] addr_in,
	input wire logic [`DATA_W-1:0] data_in,
	// bus inputs
	input wire logic bus_ready,
	input wire logic slave_valid,
	input wire logic data_rx,
	// queue full, user must hold off
	output logic master_busy,
	output serial_bus_pkg::bus_tx_t tx,
	output logic [`DATA_W-1:0] data_read,
	output logic read_done
);

	import bus_cmd_pkg::*;

	// capture to queue
	logic push;
	bus_cmd_t new_cmd;

	// queue to sequencer
	logic empty;
	logic pop;
	bus_cmd_t head_cmd;

	//////////////////////////////
	// producer
	//////////////////////////////

	cmd_capture u_cmd_capture
	(
		.clock(clock),
		.reset(reset),
		.enable(enable),
		.read_en(read_en),
		.addr_in(addr_in),
		.data_in(data_in),
		.full(master_busy),
		.push(push),
		.cmd(new_cmd)
	);

	//////////////////////////////
	// command queue
	//////////////////////////////

	cmd_fifo u_cmd_fifo
	(
		.clock(clock),
		.reset(reset),
		.push(push),
		.wr_cmd(new_cmd),
		.pop(pop),
		.rd_cmd(head_cmd),
		.full(master_busy),
		.empty(empty)
	);

	//////////////////////////////
	// consumer, drives the bus
	//////////////////////////////

	bus_sequencer u_bus_sequencer
	(
		.clock(clock),
		.reset(reset),
		.empty(empty),
		.head(head_cmd),
		.pop(pop),
		.bus_ready(bus_ready),
		.slave_valid(slave_valid),
		.data_rx(data_rx),
		.tx(tx),
		.data_read(data_read),
		.read_done(read_done)
	);

endmodule

`default_nettype wire

/* source/bus_sequencer.sv */
`timescale 1ns/100ps
`default_nettype none

`include "bus_defs.svh"

module bus_sequencer
(
	input wire logic clock,
	input wire logic reset,
	// queue side
	input wire logic empty,
	input wire bus_cmd_pkg::bus_cmd_t head,
	output logic pop,
	// bus side inputs
	input wire logic bus_ready,
	input wire logic slave_valid,
	input wire logic data_rx,
	// bus side outputs
	output serial_bus_pkg::bus_tx_t tx,
	output logic [`DATA_W-1:0] data_read,
	output logic read_done
);

	import serial_bus_pkg::*;

	seq_state_t state;
	// bit index of the current phase
	bit_cnt_t cnt;

	// shift registers, msb goes out first
	logic [`ADDR_W-1:0] addr_sr;
	logic [`DATA_W-1:0] data_sr;

	// last address cycle
	logic addr_last;
	// last read data bit
	logic data_last;
	// next address cycle also carries a write data bit
	logic data_go;

	assign addr_last = (cnt == bit_cnt_t'(`ADDR_W - 1));
	assign data_last = (cnt == bit_cnt_t'(`DATA_W - 1));
	// write data rides on the last DATA_W address bits
	assign data_go = tx.write_en_slave & ~addr_last
		& (cnt >= bit_cnt_t'(`ADDR_W - `DATA_W - 1));

	// take the head as soon as we are free
	assign pop = (state == st_idle) & ~empty;

	//////////////////////////////
	// control and bus lines
	//////////////////////////////

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= st_idle;
			cnt <= '0;
			tx <= '0;
			data_read <= '0;
			read_done <= 1'b0;
		end
		else
		begin
			// single cycle pulse
			read_done <= 1'b0;
			case (state)
				st_idle:
				begin
					if (!empty)
					begin
						tx.bus_req <= 1'b1;
						tx.write_en_slave <= ~head.read;
						state <= st_request;
					end
				end
				st_request:
				begin
					// grant seen, first address bit goes out with valid_s
					if (bus_ready)
					begin
						tx.valid_s <= 1'b1;
						tx.addr_tx <= addr_sr[`ADDR_W-1];
						tx.data_tx <= 1'b0;
						cnt <= '0;
						state <= st_address;
					end
				end
				st_address:
				begin
					if (addr_last)
					begin
						tx.valid_s <= 1'b0;
						tx.addr_tx <= 1'b0;
						tx.data_tx <= 1'b0;
						// writes are finished here, reads keep the bus
						if (tx.write_en_slave)
						begin
							tx.bus_req <= 1'b0;
							tx.write_en_slave <= 1'b0;
							state <= st_idle;
						end
						else
						begin
							state <= st_read_wait;
						end
					end
					else
					begin
						cnt <= cnt + 1'b1;
						tx.addr_tx <= addr_sr[`ADDR_W-1];
						if (data_go)
						begin
							tx.data_tx <= data_sr[`DATA_W-1];
						end
					end
				end
				st_read_wait:
				begin
					// slave answers after any delay
					if (slave_valid)
					begin
						cnt <= '0;
						state <= st_receive;
					end
				end
				st_receive:
				begin
					if (data_last)
					begin
						state <= st_done;
					end
					else
					begin
						cnt <= cnt + 1'b1;
					end
				end
				st_done:
				begin
					data_read <= data_sr;
					read_done <= 1'b1;
					tx.bus_req <= 1'b0;
					state <= st_idle;
				end
				default:
				begin
					state <= st_idle;
				end
			endcase
		end
	end

	//////////////////////////////
	// shift datapath
	//////////////////////////////

	always_ff @(posedge clock)
	begin
		case (state)
			st_idle:
			begin
				if (!empty)
				begin
					addr_sr <= head.addr;
					data_sr <= head.data;
				end
			end
			st_request:
			begin
				if (bus_ready)
				begin
					addr_sr <= {addr_sr[`ADDR_W-2:0], 1'b0};
				end
			end
			st_address:
			begin
				addr_sr <= {addr_sr[`ADDR_W-2:0], 1'b0};
				if (data_go)
				begin
					data_sr <= {data_sr[`DATA_W-2:0], 1'b0};
				end
			end
			// read word assembles msb first
			st_receive:
			begin
				data_sr <= {data_sr[`DATA_W-2:0], data_rx};
			end
			default:
			begin
				data_sr <= data_sr;
			end
		endcase
	end

	//////////////////////////////
	// checks
	//////////////////////////////

	a_valid_needs_req : assert property (
		@(posedge clock) disable iff (reset)
		tx.valid_s |-> tx.bus_req
	) else $error("bus_sequencer: valid_s without bus_req");

	// address phase is bounded
	a_valid_length : assert property (
		@(posedge clock) disable iff (reset)
		$rose(tx.valid_s) |-> ##[1:`ADDR_W] !tx.valid_s
	) else $error("bus_sequencer: valid_s longer than address phase");

endmodule

`default_nettype wire

/* source/cmd_fifo.sv */
`timescale 1ns/100ps
`default_nettype none

`include "bus_defs.svh"

module cmd_fifo
(
	input wire logic clock,
	input wire logic reset,
	// write side, from the capture logic
	input wire logic push,
	input wire bus_cmd_pkg::bus_cmd_t wr_cmd,
	// read side, from the sequencer
	input wire logic pop,
	output bus_cmd_pkg::bus_cmd_t rd_cmd,
	output logic full,
	output logic empty
);

	import bus_cmd_pkg::*;

	localparam int ptr_w = $clog2(`CMD_DEPTH);

	// entry storage
	bus_cmd_t mem [`CMD_DEPTH];

	// pointers wrap on their own, depth is a power of two
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	// one bit wider than the pointers, 0 to CMD_DEPTH
	logic [ptr_w:0] count;

	// requests that actually take effect
	logic do_push;
	logic do_pop;

	assign do_push = push & ~full;
	assign do_pop = pop & ~empty;

	//////////////////////////////
	// storage
	//////////////////////////////

	always_ff @(posedge clock)
	begin
		if (do_push)
		begin
			mem[wr_ptr] <= wr_cmd;
		end
	end

	// head shows the oldest entry
	assign rd_cmd = mem[rd_ptr];

	//////////////////////////////
	// pointers and occupancy
	//////////////////////////////

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (do_push)
			begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop)
			begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// simultaneous push and pop leaves count alone
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assign full = (count == (ptr_w + 1)'(`CMD_DEPTH));
	assign empty = (count == '0);

	//////////////////////////////
	// checks
	//////////////////////////////

	a_no_pop_when_empty : assert property (
		@(posedge clock) disable iff (reset)
		pop |-> !empty
	) else $error("cmd_fifo: pop while empty");

	a_no_push_when_full : assert property (
		@(posedge clock) disable iff (reset)
		push |-> !full
	) else $error("cmd_fifo: push while full");

endmodule

`default_nettype wire

/* source/cmd_capture.sv */
`timescale 1ns/100ps
`default_nettype none

`include "bus_defs.svh"

module cmd_capture
(
	input wire logic clock,
	input wire logic reset,
	// user strobe, one command per rising edge
	input wire logic enable,
	input wire logic read_en,
	input wire logic [`ADDR_W-1:0] addr_in,
	input wire logic [`DATA_W-1:0] data_in,
	// queue has no room
	input wire logic full,
	output logic push,
	output bus_cmd_pkg::bus_cmd_t cmd
);

	import bus_cmd_pkg::*;

	// [0] newest sample, [1] the one before
	logic [1:0] enable_hist;
	logic enable_rise;

	//////////////////////////////
	// enable edge detect
	//////////////////////////////

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			enable_hist <= 2'b00;
		end
		else
		begin
			enable_hist <= {enable_hist[0], enable};
		end
	end

	// high for one cycle, the cycle after enable rises
	assign enable_rise = enable_hist[0] & ~enable_hist[1];

	// edge while queue is full is simply lost
	assign push = enable_rise & ~full;

	// user inputs taken as they stand in the push cycle
	assign cmd = bus_cmd_t'{read: read_en, addr: addr_in, data: data_in};

endmodule

`default_nettype wire

/* source/serial_bus_pkg.sv */
`default_nettype none

`include "bus_defs.svh"

package serial_bus_pkg;

	//////////////////////////////
	// sequencer states
	//////////////////////////////

	typedef enum logic [2:0]
	{
		st_idle,
		// bus_req up, waiting for bus_ready
		st_request,
		// valid_s up, address (and write data) shifting
		st_address,
		// read only, waiting for slave_valid
		st_read_wait,
		// read only, shifting data_rx in
		st_receive,
		// read only, hand word to user
		st_done
	} seq_state_t;

	// bit index within a phase, wide enough for the address
	typedef logic [$clog2(`ADDR_W)-1:0] bit_cnt_t;

	//////////////////////////////
	// lines driven by the master
	//////////////////////////////

	typedef struct packed
	{
		logic bus_req;
		logic valid_s;
		logic write_en_slave;
		logic addr_tx;
		logic data_tx;
	} bus_tx_t;

endpackage

`default_nettype wire

/* source/bus_cmd_pkg.sv */
`default_nettype none

`include "bus_defs.svh"

package bus_cmd_pkg;

	//////////////////////////////
	// user side command
	//////////////////////////////

	// one posted command as it sits in the queue
	// read = 1 selects a read, data is ignored then
	typedef struct packed
	{
		// transfer direction
		logic read;
		// target address, sent msb first
		logic [`ADDR_W-1:0] addr;
		// write payload, sent msb first
		logic [`DATA_W-1:0] data;
	} bus_cmd_t;

endpackage

`default_nettype wire

/* source/bus_defs.svh */
`ifndef BUS_DEFS_SVH
`define BUS_DEFS_SVH

//////////////////////////////
// serial bus geometry
//////////////////////////////

// address bits shifted out per transfer
`define ADDR_W 14

// data bits per word, both directions
`define DATA_W 8

// command queue entries, power of two, 2 or more
`define CMD_DEPTH 4

`endif
